// File: sources.f
design/cpu_pkg.sv
design/alu.sv
design/exe_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/data_sram.sv
design/cpu_backend.sv
verification/backend_assertions.sv
verification/tb_cpu_backend.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_cpu_backend -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cpu_backend)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verification/tb_cpu_backend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_backend;
    import cpu_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 6;
    // Clock edges used by all tests with bubbles counted at their maximum
    localparam int TEST_SLOTS = 66;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_SLOTS + 20;

    logic      clk;
    logic      reset;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    logic      es_allowin;
    stall_t    stall_es;
    forward_t  forward_es;
    rf_write_t rf_write;

    word_t     rng_state = 32'd25025;
    int        edge_cnt = 0;
    int        value_errors = 0;
    int        other_errors = 0;
    rf_write_t exp_q [$];
    int        edge_q [$];
    word_t     mem_model [int];

    cpu_backend UUT (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .stall_es       (stall_es),
        .forward_es     (forward_es),
        .rf_write       (rf_write)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ############################################################
    // Random numbers and reference model
    // ############################################################

    function automatic word_t next_rand();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
        word_t r;
        r = '0;
        if (op[ALU_ADD])       r = a + b;
        else if (op[ALU_SUB])  r = a - b;
        else if (op[ALU_SLT])  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        else if (op[ALU_SLTU]) r = (a < b) ? 32'd1 : 32'd0;
        else if (op[ALU_AND])  r = a & b;
        else if (op[ALU_NOR])  r = ~(a | b);
        else if (op[ALU_OR])   r = a | b;
        else if (op[ALU_XOR])  r = a ^ b;
        else if (op[ALU_SLL])  r = b << a[4:0];
        else if (op[ALU_SRL])  r = b >> a[4:0];
        else if (op[ALU_SRA])  r = word_t'($signed(b) >>> a[4:0]);
        else if (op[ALU_LUI])  r = {b[15:0], 16'h0000};
        return r;
    endfunction

    function automatic word_t expected_alu(input ds_to_es_t d);
        word_t a;
        word_t b;
        if (d.src1_is_sa)      a = {27'd0, d.imm.shift_fields.sa};
        else if (d.src1_is_pc) a = d.pc;
        else                   a = d.rs_value;
        if (d.src2_is_imm)     b = {{16{d.imm.imm[15]}}, d.imm.imm};
        else if (d.src2_is_8)  b = 32'd8;
        else                   b = d.rt_value;
        return ref_alu(d.alu_op, a, b);
    endfunction

    function automatic ds_to_es_t random_op(input int op_bit);
        ds_to_es_t d;
        d = '0;
        d.alu_op[op_bit] = 1'b1;
        d.gr_we = 1'b1;
        d.dest = reg_addr_t'(next_rand());
        d.imm.imm = 16'(next_rand());
        d.rs_value = next_rand();
        d.rt_value = next_rand();
        d.pc = next_rand() & 32'hffff_fffc;
        return d;
    endfunction

    function automatic ds_to_es_t random_store();
        ds_to_es_t d;
        d = random_op(ALU_ADD);
        d.src2_is_imm = 1'b1;
        d.mem_we = 1'b1;
        d.gr_we = 1'b0;
        return d;
    endfunction

    // ############################################################
    // Compare tasks
    // ############################################################

    task automatic check_rf_write(input rf_write_t got, input rf_write_t exp, input string what);
        if (got.we !== exp.we ||
            (exp.we && (got.addr !== exp.addr || got.data !== exp.data))) begin
            value_errors++;
            $display("** Error at %0t: %s got we=%b addr=%0d data=%h, expected we=%b addr=%0d data=%h",
                     $time, what, got.we, got.addr, got.data, exp.we, exp.addr, exp.data);
        end
    endtask

    task automatic check_stall(input stall_t got, input stall_t exp, input string what);
        if (got.valid !== exp.valid || (exp.valid && got.dest !== exp.dest)) begin
            value_errors++;
            $display("** Error at %0t: %s got valid=%b dest=%0d, expected valid=%b dest=%0d",
                     $time, what, got.valid, got.dest, exp.valid, exp.dest);
        end
    endtask

    task automatic check_forward(input forward_t got, input forward_t exp, input string what);
        if (got.valid !== exp.valid || (exp.valid && got.value !== exp.value)) begin
            value_errors++;
            $display("** Error at %0t: %s got valid=%b value=%h, expected valid=%b value=%h",
                     $time, what, got.valid, got.value, exp.valid, exp.value);
        end
    endtask

    // Register writes must arrive in order and three cycles after acceptance
    always @(negedge clk) begin : monitor
        rf_write_t exp_w;
        int        exp_edge;
        if (!reset) begin
            if (ds_to_es_valid && !es_allowin) begin
                other_errors++;
                $display("Execute stage refused an op at time %0t", $time);
            end
            if (edge_q.size() > 0 && edge_cnt > edge_q[0]) begin
                other_errors++;
                $display("A register write due at cycle %0d never appeared", edge_q[0]);
                exp_edge = edge_q.pop_front();
                exp_w = exp_q.pop_front();
            end
            if (rf_write.we) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("Unexpected register write at time %0t", $time);
                end else begin
                    exp_w = exp_q.pop_front();
                    exp_edge = edge_q.pop_front();
                    check_rf_write(rf_write, exp_w, "register write");
                    if (edge_cnt != exp_edge) begin
                        other_errors++;
                        $display("Register write came at cycle %0d instead of cycle %0d",
                                 edge_cnt, exp_edge);
                    end
                end
            end
        end
    end

    // ############################################################
    // Stimulus and tests
    // ############################################################

    task automatic send_op(input ds_to_es_t d);
        word_t     result;
        rf_write_t exp;
        int        addr;
        result = expected_alu(d);
        addr = int'(result[9:2]);
        @(posedge clk);
        ds_to_es_valid <= 1'b1;
        ds_to_es_bus <= d;
        if (d.mem_we) begin
            mem_model[addr] = d.rt_value;
        end
        if (d.gr_we) begin
            exp.we = 1'b1;
            exp.addr = d.dest;
            exp.data = d.load_op ? mem_model[addr] : result;
            exp_q.push_back(exp);
            // Accepted on the next edge and in write-back two edges after that
            edge_q.push_back(edge_cnt + 4);
        end
    endtask

    task automatic insert_bubbles(input int n);
        repeat (n) begin
            @(posedge clk);
            ds_to_es_valid <= 1'b0;
        end
    endtask

    task automatic test_alu_reg_ops();
        for (int k = 0; k < 12; k++) begin
            send_op(random_op(k));
        end
        insert_bubbles(1);
    endtask

    task automatic test_imm_forms();
        ds_to_es_t d;
        d = random_op(ALU_ADD);
        d.src2_is_imm = 1'b1;
        send_op(d);
        d = random_op(ALU_SLT);
        d.src2_is_imm = 1'b1;
        send_op(d);
        d = random_op(ALU_SLL);
        d.src1_is_sa = 1'b1;
        send_op(d);
        d = random_op(ALU_SRL);
        d.src1_is_sa = 1'b1;
        send_op(d);
        d = random_op(ALU_SRA);
        d.src1_is_sa = 1'b1;
        send_op(d);
        insert_bubbles(1);
    endtask

    task automatic test_link();
        ds_to_es_t d;
        d = random_op(ALU_ADD);
        d.src1_is_pc = 1'b1;
        d.src2_is_8 = 1'b1;
        send_op(d);
        insert_bubbles(1);
    endtask

    task automatic test_store_load();
        ds_to_es_t st_a;
        ds_to_es_t st_b;
        ds_to_es_t ld_a;
        ds_to_es_t ld_b;
        st_a = random_store();
        st_b = random_store();
        ld_a = st_a;
        ld_a.mem_we = 1'b0;
        ld_a.load_op = 1'b1;
        ld_a.gr_we = 1'b1;
        ld_a.rt_value = next_rand();
        ld_b = st_b;
        ld_b.mem_we = 1'b0;
        ld_b.load_op = 1'b1;
        ld_b.gr_we = 1'b1;
        send_op(st_a);
        send_op(st_b);
        send_op(ld_a);
        send_op(ld_b);
        insert_bubbles(1);
    endtask

    // Looks at the hazard buses while the op is in execute and again after a bubble
    task automatic probe_exe_buses(input ds_to_es_t d);
        stall_t   exp_stall;
        forward_t exp_fwd;
        exp_stall.valid = d.gr_we;
        exp_stall.dest = d.dest;
        exp_fwd.valid = !d.load_op;
        exp_fwd.value = expected_alu(d);
        send_op(d);
        @(posedge clk);
        ds_to_es_valid <= 1'b0;
        @(negedge clk);
        check_stall(stall_es, exp_stall, "stall bus with op in execute");
        check_forward(forward_es, exp_fwd, "forward bus with op in execute");
        @(posedge clk);
        @(negedge clk);
        check_stall(stall_es, '0, "stall bus after bubble");
        check_forward(forward_es, '0, "forward bus after bubble");
    endtask

    task automatic test_exe_buses();
        ds_to_es_t st;
        ds_to_es_t ld;
        st = random_store();
        ld = st;
        ld.mem_we = 1'b0;
        ld.load_op = 1'b1;
        ld.gr_we = 1'b1;
        probe_exe_buses(st);
        probe_exe_buses(ld);
        probe_exe_buses(random_op(ALU_XOR));
    endtask

    task automatic test_bubbles();
        int gap;
        for (int i = 0; i < 8; i++) begin
            send_op(random_op(int'(next_rand() % 32'd12)));
            gap = int'(next_rand() % 32'd3);
            insert_bubbles(gap);
        end
        insert_bubbles(1);
    endtask

    initial begin
        reset = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_rf_write(rf_write, '0, "register write after reset");
        check_stall(stall_es, '0, "stall bus after reset");
        check_forward(forward_es, '0, "forward bus after reset");

        test_alu_reg_ops();
        test_imm_forms();
        test_link();
        test_store_load();
        test_exe_buses();
        test_bubbles();

        insert_bubbles(DRAIN_CYCLES);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            other_errors += exp_q.size();
            $display("%0d expected register writes were still pending at the end", exp_q.size());
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/backend_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module backend_assertions (
    input logic              clk,
    input logic              reset,
    input logic              es_valid,
    input logic [3:0]        wen,
    input cpu_pkg::forward_t forward_es,
    input logic              es_to_ms_valid
);

    // No memory write from an empty execute stage
    wen_idle: assert property (@(posedge clk) disable iff (reset)
        !es_valid |-> wen == 4'h0)
        else $error("data memory write strobes active while execute stage is empty");

    forward_needs_valid: assert property (@(posedge clk) disable iff (reset)
        forward_es.valid |-> es_valid)
        else $error("forward bus valid while execute stage is empty");

    empty_after_reset: assert property (@(posedge clk)
        reset |=> !es_to_ms_valid)
        else $error("execute stage passes an op right after reset");

endmodule

bind exe_stage backend_assertions u_backend_assertions (
    .clk            (clk),
    .reset          (reset),
    .es_valid       (es_valid),
    .wen            (data_sram_wen),
    .forward_es     (forward_es),
    .es_to_ms_valid (es_to_ms_valid)
);

`default_nettype wire

// File: design/cpu_backend.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_backend (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_to_es_valid,
    input  cpu_pkg::ds_to_es_t ds_to_es_bus,
    output logic               es_allowin,
    output cpu_pkg::stall_t    stall_es,
    output cpu_pkg::forward_t  forward_es,
    output cpu_pkg::rf_write_t rf_write
);
    import cpu_pkg::*;

    logic                ms_allowin;
    logic                ws_allowin;
    logic                es_to_ms_valid;
    es_to_ms_t           es_to_ms_bus;
    logic                ms_to_ws_valid;
    ms_to_ws_t           ms_to_ws_bus;

    logic                data_sram_en;
    logic [3:0]          data_sram_wen;
    logic [DSRAM_AW-1:0] data_sram_addr;
    word_t               data_sram_wdata;
    word_t               data_sram_rdata;

    exe_stage u_exe_stage (
        .clk             (clk),
        .reset           (reset),
        .ms_allowin      (ms_allowin),
        .es_allowin      (es_allowin),
        .ds_to_es_valid  (ds_to_es_valid),
        .ds_to_es_bus    (ds_to_es_bus),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_to_ms_bus    (es_to_ms_bus),
        .stall_es        (stall_es),
        .forward_es      (forward_es),
        .data_sram_en    (data_sram_en),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .reset           (reset),
        .ws_allowin      (ws_allowin),
        .ms_allowin      (ms_allowin),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_to_ms_bus    (es_to_ms_bus),
        .ms_to_ws_valid  (ms_to_ws_valid),
        .ms_to_ws_bus    (ms_to_ws_bus),
        .data_sram_rdata (data_sram_rdata)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .rf_write       (rf_write)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .en    (data_sram_en),
        .wen   (data_sram_wen),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

endmodule

`default_nettype wire

// File: design/data_sram.sv
`timescale 1ns/1ns
`default_nettype none

module data_sram (
    input  logic                         clk,
    input  logic                         en,
    input  logic [3:0]                   wen,
    input  logic [cpu_pkg::DSRAM_AW-1:0] addr,
    input  cpu_pkg::word_t               wdata,
    output cpu_pkg::word_t               rdata
);
    import cpu_pkg::*;

    word_t mem [DSRAM_DEPTH];

    // Read returns the old word when a write hits the same address
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (wen[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: design/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module wb_stage (
    input  logic               clk,
    input  logic               reset,
    output logic               ws_allowin,
    input  logic               ms_to_ws_valid,
    input  cpu_pkg::ms_to_ws_t ms_to_ws_bus,
    output cpu_pkg::rf_write_t rf_write
);
    import cpu_pkg::*;

    logic      ws_valid;
    logic      ws_ready_go;
    ms_to_ws_t ws_bus;

    // Last stage, nothing downstream to wait for
    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    assign rf_write.we   = ws_valid && ws_bus.gr_we;
    assign rf_write.addr = ws_bus.dest;
    assign rf_write.data = ws_bus.final_result;

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ws_allowin,
    output logic               ms_allowin,
    input  logic               es_to_ms_valid,
    input  cpu_pkg::es_to_ms_t es_to_ms_bus,
    output logic               ms_to_ws_valid,
    output cpu_pkg::ms_to_ws_t ms_to_ws_bus,
    input  cpu_pkg::word_t     data_sram_rdata
);
    import cpu_pkg::*;

    logic      ms_valid;
    logic      ms_ready_go;
    es_to_ms_t ms_bus;

    assign ms_ready_go    = 1'b1;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    // Read data arrives this cycle for the address sent from execute
    assign ms_to_ws_bus.gr_we        = ms_bus.gr_we;
    assign ms_to_ws_bus.dest         = ms_bus.dest;
    assign ms_to_ws_bus.final_result = ms_bus.res_from_mem ? data_sram_rdata
                                                           : ms_bus.alu_result;
    assign ms_to_ws_bus.pc           = ms_bus.pc;

endmodule

`default_nettype wire

// File: design/exe_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exe_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ms_allowin,
    output logic                      es_allowin,
    input  logic                      ds_to_es_valid,
    input  cpu_pkg::ds_to_es_t        ds_to_es_bus,
    output logic                      es_to_ms_valid,
    output cpu_pkg::es_to_ms_t        es_to_ms_bus,
    output cpu_pkg::stall_t           stall_es,
    output cpu_pkg::forward_t         forward_es,
    output logic                      data_sram_en,
    output logic [3:0]                data_sram_wen,
    output logic [cpu_pkg::DSRAM_AW-1:0] data_sram_addr,
    output cpu_pkg::word_t            data_sram_wdata
);
    import cpu_pkg::*;

    logic      es_valid;
    logic      es_ready_go;
    ds_to_es_t es_bus;
    word_t     alu_src1;
    word_t     alu_src2;
    word_t     alu_result;

    // ############################################################
    // Pipeline register
    // ############################################################

    assign es_ready_go    = 1'b1;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_bus <= ds_to_es_bus;
        end
    end

    // ############################################################
    // Operands and ALU
    // ############################################################

    assign alu_src1 = es_bus.src1_is_sa ? {27'b0, es_bus.imm.shift_fields.sa} :
                      es_bus.src1_is_pc ? es_bus.pc :
                                          es_bus.rs_value;

    assign alu_src2 = es_bus.src2_is_imm ? word_t'(es_bus.imm.imm) :
                      es_bus.src2_is_8   ? word_t'(8) :
                                           es_bus.rt_value;

    alu u_alu (
        .op     (es_bus.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign es_to_ms_bus.res_from_mem = es_bus.load_op;
    assign es_to_ms_bus.gr_we        = es_bus.gr_we;
    assign es_to_ms_bus.dest         = es_bus.dest;
    assign es_to_ms_bus.alu_result   = alu_result;
    assign es_to_ms_bus.pc           = es_bus.pc;

    // Hazard info for decode
    assign stall_es.valid   = es_valid && es_bus.gr_we;
    assign stall_es.dest    = es_bus.dest;
    // A load's value is not known yet in execute
    assign forward_es.valid = es_valid && !es_bus.load_op;
    assign forward_es.value = alu_result;

    // Data memory, word addressed
    assign data_sram_en    = 1'b1;
    assign data_sram_wen   = (es_valid && es_bus.mem_we) ? 4'hf : 4'h0;
    assign data_sram_addr  = alu_result[DSRAM_AW+1:2];
    assign data_sram_wdata = es_bus.rt_value;

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   src1,
    input  cpu_pkg::word_t   src2,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    logic          do_sub;
    word_t         adder_b;
    logic [WORD_W:0] adder_sum;
    logic          slt_bit;
    logic          sltu_bit;
    word_t         sll_res;
    word_t         srl_res;
    word_t         sra_res;
    word_t         lui_res;

    // Shared adder; sub and both compares use src1 + ~src2 + 1
    assign do_sub    = op[ALU_SUB] | op[ALU_SLT] | op[ALU_SLTU];
    assign adder_b   = do_sub ? ~src2 : src2;
    assign adder_sum = {1'b0, src1} + {1'b0, adder_b} + {{WORD_W{1'b0}}, do_sub};

    assign slt_bit  = (src1[WORD_W-1] & ~src2[WORD_W-1])
                    | (~(src1[WORD_W-1] ^ src2[WORD_W-1]) & adder_sum[WORD_W-1]);
    // No carry out means a borrow, so src1 < src2 unsigned
    assign sltu_bit = ~adder_sum[WORD_W];

    assign sll_res = src2 << src1[4:0];
    assign srl_res = src2 >> src1[4:0];
    assign sra_res = word_t'($signed(src2) >>> src1[4:0]);
    assign lui_res = {src2[15:0], 16'b0};

    assign result = ({WORD_W{op[ALU_ADD] | op[ALU_SUB]}} & adder_sum[WORD_W-1:0])
                  | ({WORD_W{op[ALU_SLT]}}  & {{(WORD_W-1){1'b0}}, slt_bit})
                  | ({WORD_W{op[ALU_SLTU]}} & {{(WORD_W-1){1'b0}}, sltu_bit})
                  | ({WORD_W{op[ALU_AND]}}  & (src1 & src2))
                  | ({WORD_W{op[ALU_NOR]}}  & ~(src1 | src2))
                  | ({WORD_W{op[ALU_OR]}}   & (src1 | src2))
                  | ({WORD_W{op[ALU_XOR]}}  & (src1 ^ src2))
                  | ({WORD_W{op[ALU_SLL]}}  & sll_res)
                  | ({WORD_W{op[ALU_SRL]}}  & srl_res)
                  | ({WORD_W{op[ALU_SRA]}}  & sra_res)
                  | ({WORD_W{op[ALU_LUI]}}  & lui_res);

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_W      = 32;
    localparam int REG_AW      = 5;
    localparam int ALU_OP_W    = 12;
    localparam int DSRAM_DEPTH = 256;
    localparam int DSRAM_AW    = 8;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [REG_AW-1:0]   reg_addr_t;
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    // Bit positions in the one-hot ALU op vector
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // Same 16 bits read as immediate or as the shift-amount slot (instr bits 10:6)
    typedef struct packed {
        logic [4:0] unused_hi;
        logic [4:0] sa;
        logic [5:0] unused_lo;
    } shift_fields_t;

    typedef union packed {
        logic signed [15:0] imm;
        shift_fields_t      shift_fields;
    } imm_u;

    // ############################################################
    // Stage buses
    // ############################################################

    typedef struct packed {
        alu_op_t   alu_op;
        logic      load_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_8;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        imm_u      imm;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
    } ds_to_es_t;

    typedef struct packed {
        logic      res_from_mem;
        logic      gr_we;
        reg_addr_t dest;
        word_t     alu_result;
        word_t     pc;
    } es_to_ms_t;

    typedef struct packed {
        logic      gr_we;
        reg_addr_t dest;
        word_t     final_result;
        word_t     pc;
    } ms_to_ws_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
    } stall_t;

    typedef struct packed {
        logic  valid;
        word_t value;
    } forward_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

endpackage

`default_nettype wire
